// ==== logic/cpu_consts.svh ====
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// datapath and instruction word width
`define CPU_DATA_W 16

// word counts of the two memories
`define CPU_IMEM_WORDS 256
`define CPU_DMEM_WORDS 256

// word index width, byte address bits [8:1]
`define CPU_ADDR_W 8

// byte address bit that routes a store to the output port
`define CPU_IO_BIT 15

`endif

// ==== logic/cpu_decode.sv ====
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpu_decode (
  input  logic                  clk,
  input  logic                  rst_n,
  input  cpu_pipe_pkg::if_id_t  if_id,
  input  cpu_pipe_pkg::fwd_t    wb_fwd,
  output cpu_pipe_pkg::id_ex_t  id_ex,
  output logic                  halt_seen
);

  cpu_isa_pkg::instr_t    instr;
  logic [3:0]             rt_sel;
  logic [`CPU_DATA_W-1:0] rs_val;
  logic [`CPU_DATA_W-1:0] rt_val;
  cpu_pipe_pkg::id_ex_t   id_ex_d;

  assign instr = if_id.instr;

  // SW reads its data register through the rt port
  assign rt_sel = (instr.opcode == cpu_isa_pkg::OP_SW) ? instr.rd : instr.rt_imm;

  // stops fetch right away, IF/ID behind it becomes a bubble
  assign halt_seen = if_id.valid && (instr.opcode == cpu_isa_pkg::OP_HLT);

  cpu_regfile cpu_regfile_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .rs      (instr.rs),
    .rt      (rt_sel),
    .wr_en   (wb_fwd.reg_write),
    .wr_addr (wb_fwd.rd),
    .wr_data (wb_fwd.value),
    .rs_val  (rs_val),
    .rt_val  (rt_val)
  );

  always_comb begin
    id_ex_d        = '0;
    id_ex_d.op     = instr.opcode;
    id_ex_d.rd     = instr.rd;
    id_ex_d.rs     = instr.rs;
    id_ex_d.rt     = rt_sel;
    id_ex_d.rs_val = rs_val;
    id_ex_d.rt_val = rt_val;
    case (instr.opcode)
      cpu_isa_pkg::OP_ADD, cpu_isa_pkg::OP_SUB, cpu_isa_pkg::OP_XOR: begin
        id_ex_d.valid     = if_id.valid;
        id_ex_d.reg_write = 1'b1;
      end
      // shift amount straight from the low nibble
      cpu_isa_pkg::OP_SLL, cpu_isa_pkg::OP_SRA, cpu_isa_pkg::OP_ROR: begin
        id_ex_d.valid     = if_id.valid;
        id_ex_d.reg_write = 1'b1;
        id_ex_d.use_imm   = 1'b1;
        id_ex_d.imm       = {12'h000, instr.rt_imm};
      end
      // word offset, sign extended then doubled to a byte offset
      cpu_isa_pkg::OP_LW, cpu_isa_pkg::OP_SW: begin
        id_ex_d.valid     = if_id.valid;
        id_ex_d.reg_write = (instr.opcode == cpu_isa_pkg::OP_LW);
        id_ex_d.mem_read  = (instr.opcode == cpu_isa_pkg::OP_LW);
        id_ex_d.mem_write = (instr.opcode == cpu_isa_pkg::OP_SW);
        id_ex_d.use_imm   = 1'b1;
        id_ex_d.imm       = {{11{instr.rt_imm[3]}}, instr.rt_imm, 1'b0};
      end
      cpu_isa_pkg::OP_LLB: begin
        id_ex_d.valid     = if_id.valid;
        id_ex_d.reg_write = 1'b1;
        id_ex_d.use_imm   = 1'b1;
        id_ex_d.imm       = {8'h00, instr.rs, instr.rt_imm};
      end
      // HLT rides down the pipe with no side effects
      cpu_isa_pkg::OP_HLT: id_ex_d.valid = if_id.valid;
      default: id_ex_d.valid = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      id_ex <= '0;
    end else begin
      id_ex <= id_ex_d;
    end
  end

endmodule

// ==== logic/cpu_execute.sv ====
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpu_execute (
  input  logic                  clk,
  input  logic                  rst_n,
  input  cpu_pipe_pkg::id_ex_t  id_ex,
  input  cpu_pipe_pkg::fwd_t    mem_fwd,
  input  cpu_pipe_pkg::fwd_t    wb_fwd,
  output cpu_pipe_pkg::ex_mem_t ex_mem,
  output cpu_isa_pkg::flags_t   flags
);

  logic [`CPU_DATA_W-1:0]   rs_op;
  logic [`CPU_DATA_W-1:0]   rt_op;
  logic [`CPU_DATA_W-1:0]   a_op;
  logic [`CPU_DATA_W-1:0]   b_op;
  logic [2*`CPU_DATA_W-1:0] rot;
  logic [`CPU_DATA_W-1:0]   alu_y;
  logic                     alu_v;
  cpu_pipe_pkg::ex_mem_t    ex_mem_d;

  // memory stage is newer than writeback so it wins, r0 is never forwarded
  function automatic logic [`CPU_DATA_W-1:0] fwd_pick(
    input logic [3:0]             src,
    input logic [`CPU_DATA_W-1:0] decoded,
    input cpu_pipe_pkg::fwd_t     near,
    input cpu_pipe_pkg::fwd_t     far
  );
    logic [`CPU_DATA_W-1:0] pick;
    pick = decoded;
    if (src != 4'd0 && far.reg_write && far.rd == src) begin
      pick = far.value;
    end
    if (src != 4'd0 && near.reg_write && near.rd == src) begin
      pick = near.value;
    end
    return pick;
  endfunction

  assign rs_op = fwd_pick(id_ex.rs, id_ex.rs_val, mem_fwd, wb_fwd);
  // for SW this is the store data
  assign rt_op = fwd_pick(id_ex.rt, id_ex.rt_val, mem_fwd, wb_fwd);

  assign a_op = rs_op;
  assign b_op = id_ex.use_imm ? id_ex.imm : rt_op;

  // rotate by shifting a doubled copy
  assign rot = {a_op, a_op} >> b_op[3:0];

  always_comb begin
    alu_y = a_op + b_op;
    alu_v = 1'b0;
    case (id_ex.op)
      // overflow when like signs give a result of the other sign
      cpu_isa_pkg::OP_ADD: alu_v = (a_op[15] == b_op[15]) && (alu_y[15] != a_op[15]);
      cpu_isa_pkg::OP_SUB: begin
        alu_y = a_op - b_op;
        alu_v = (a_op[15] != b_op[15]) && (alu_y[15] != a_op[15]);
      end
      cpu_isa_pkg::OP_XOR: alu_y = a_op ^ b_op;
      cpu_isa_pkg::OP_SLL: alu_y = a_op << b_op[3:0];
      cpu_isa_pkg::OP_SRA: alu_y = $signed(a_op) >>> b_op[3:0];
      cpu_isa_pkg::OP_ROR: alu_y = rot[`CPU_DATA_W-1:0];
      // LW and SW keep the sum as the byte address
      cpu_isa_pkg::OP_LLB: alu_y = b_op;
      default: ;
    endcase
  end

  always_comb begin
    ex_mem_d            = '0;
    ex_mem_d.valid      = id_ex.valid;
    ex_mem_d.result     = alu_y;
    ex_mem_d.store_data = rt_op;
    ex_mem_d.rd         = id_ex.rd;
    ex_mem_d.reg_write  = id_ex.reg_write;
    ex_mem_d.mem_read   = id_ex.mem_read;
    ex_mem_d.mem_write  = id_ex.mem_write;
    ex_mem_d.is_halt    = (id_ex.op == cpu_isa_pkg::OP_HLT);
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ex_mem <= '0;
    end else begin
      ex_mem <= ex_mem_d;
    end
  end

  // Z on arithmetic, logic and shifts, V and N on ADD and SUB only
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      flags <= '0;
    end else if (id_ex.valid) begin
      case (id_ex.op)
        cpu_isa_pkg::OP_ADD, cpu_isa_pkg::OP_SUB: begin
          flags.v <= alu_v;
          flags.n <= alu_y[`CPU_DATA_W-1];
          flags.z <= (alu_y == '0);
        end
        cpu_isa_pkg::OP_XOR, cpu_isa_pkg::OP_SLL,
        cpu_isa_pkg::OP_SRA, cpu_isa_pkg::OP_ROR: flags.z <= (alu_y == '0);
        default: ;
      endcase
    end
  end

endmodule

// ==== logic/cpu_fetch.sv ====
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpu_fetch (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    prog_we,
  input  logic [`CPU_ADDR_W-1:0]  prog_addr,
  input  logic [`CPU_DATA_W-1:0]  prog_data,
  input  logic                    halt_seen,
  output logic [`CPU_DATA_W-1:0]  pc,
  output cpu_pipe_pkg::if_id_t    if_id
);

  logic [`CPU_DATA_W-1:0] imem [`CPU_IMEM_WORDS];
  logic                   halted;
  logic                   stop;
  logic [`CPU_DATA_W-1:0] fetch_word;

  // program load only while the core sits in reset
  always_ff @(posedge clk) begin
    if (!rst_n && prog_we) begin
      imem[prog_addr] <= prog_data;
    end
  end

  // word index is the byte pc without its low bit
  assign fetch_word = imem[pc[`CPU_ADDR_W:1]];

  // decode flags HLT one cycle before the latch catches it,
  // so the pc after HLT is never passed
  assign stop = halted | halt_seen;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      halted <= 1'b0;
    end else if (halt_seen) begin
      halted <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= '0;
    end else if (!stop) begin
      pc <= pc + `CPU_DATA_W'(2);
    end
  end

  // bubbles behind HLT
  always_ff @(posedge clk) begin
    if (!rst_n || stop) begin
      if_id <= '0;
    end else begin
      if_id.valid <= 1'b1;
      if_id.instr <= cpu_isa_pkg::instr_t'(fetch_word);
    end
  end

endmodule

// ==== logic/cpu_isa_pkg.sv ====
`include "cpu_consts.svh"

package cpu_isa_pkg;

  // 4-bit opcode field, unlisted codes are treated as no-op
  typedef enum logic [3:0] {
    OP_ADD = 4'h0,
    OP_SUB = 4'h1,
    OP_XOR = 4'h2,
    OP_SLL = 4'h4,
    OP_SRA = 4'h5,
    OP_ROR = 4'h6,
    OP_LW  = 4'h8,
    OP_SW  = 4'h9,
    OP_LLB = 4'hA,
    OP_HLT = 4'hF
  } opcode_e;

  // instruction word layout
  // rd is the data register for SW, {rs, rt_imm} is the LLB byte
  typedef struct packed {
    opcode_e    opcode;
    logic [3:0] rd;
    logic [3:0] rs;
    logic [3:0] rt_imm;
  } instr_t;

  // alu status, same bit order as the classic {V, N, Z}
  typedef struct packed {
    logic v;
    logic n;
    logic z;
  } flags_t;

endpackage

// ==== logic/cpu_memory.sv ====
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpu_memory (
  input  logic                    clk,
  input  logic                    rst_n,
  input  cpu_pipe_pkg::ex_mem_t   ex_mem,
  output cpu_pipe_pkg::fwd_t      mem_fwd,
  output cpu_pipe_pkg::fwd_t      wb_fwd,
  output logic                    io_valid,
  output cpu_pipe_pkg::io_write_t io_wr,
  output logic                    hlt
);

  logic [`CPU_DATA_W-1:0] dmem [`CPU_DMEM_WORDS];
  logic [`CPU_ADDR_W-1:0] word_idx;
  logic [`CPU_DATA_W-1:0] load_data;
  logic                   is_io;
  logic [`CPU_DATA_W-1:0] stage_value;
  cpu_pipe_pkg::mem_wb_t  mem_wb;

  assign word_idx = ex_mem.result[`CPU_ADDR_W:1];
  assign is_io    = ex_mem.result[`CPU_IO_BIT];

  // combinational read, feeds load-use forwarding in the same cycle
  assign load_data   = dmem[word_idx];
  assign stage_value = ex_mem.mem_read ? load_data : ex_mem.result;

  // high half of the address space goes to the output port instead
  always_ff @(posedge clk) begin
    if (ex_mem.valid && ex_mem.mem_write && !is_io) begin
      dmem[word_idx] <= ex_mem.store_data;
    end
  end

  // single cycle strobe, data held until the next port write
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      io_valid <= 1'b0;
    end else begin
      io_valid <= ex_mem.valid && ex_mem.mem_write && is_io;
    end
  end

  always_ff @(posedge clk) begin
    if (ex_mem.valid && ex_mem.mem_write && is_io) begin
      io_wr.addr <= ex_mem.result[`CPU_IO_BIT-1:0];
      io_wr.data <= ex_mem.store_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mem_wb <= '0;
    end else begin
      mem_wb.valid     <= ex_mem.valid;
      mem_wb.rd        <= ex_mem.rd;
      mem_wb.reg_write <= ex_mem.reg_write;
      mem_wb.result    <= stage_value;
      mem_wb.is_halt   <= ex_mem.is_halt;
    end
  end

  assign mem_fwd.rd        = ex_mem.rd;
  assign mem_fwd.reg_write = ex_mem.valid && ex_mem.reg_write;
  assign mem_fwd.value     = stage_value;

  // also the register file write port
  assign wb_fwd.rd        = mem_wb.rd;
  assign wb_fwd.reg_write = mem_wb.valid && mem_wb.reg_write;
  assign wb_fwd.value     = mem_wb.result;

  // sticky until reset, set as HLT retires
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      hlt <= 1'b0;
    end else if (mem_wb.valid && mem_wb.is_halt) begin
      hlt <= 1'b1;
    end
  end

endmodule

// ==== logic/cpu_pipe_pkg.sv ====
`include "cpu_consts.svh"

package cpu_pipe_pkg;

  // fetch to decode
  typedef struct packed {
    logic                valid;
    cpu_isa_pkg::instr_t instr;
  } if_id_t;

  // decode to execute, register values as read in decode
  typedef struct packed {
    logic                     valid;
    cpu_isa_pkg::opcode_e     op;
    logic [3:0]               rd;
    logic [3:0]               rs;
    logic [3:0]               rt;
    logic [`CPU_DATA_W-1:0]   rs_val;
    logic [`CPU_DATA_W-1:0]   rt_val;
    logic [`CPU_DATA_W-1:0]   imm;
    logic                     use_imm;
    logic                     reg_write;
    logic                     mem_read;
    logic                     mem_write;
  } id_ex_t;

  // execute to memory, result doubles as the byte address
  typedef struct packed {
    logic                   valid;
    logic [`CPU_DATA_W-1:0] result;
    logic [`CPU_DATA_W-1:0] store_data;
    logic [3:0]             rd;
    logic                   reg_write;
    logic                   mem_read;
    logic                   mem_write;
    logic                   is_halt;
  } ex_mem_t;

  // memory to writeback
  typedef struct packed {
    logic                   valid;
    logic [3:0]             rd;
    logic                   reg_write;
    logic [`CPU_DATA_W-1:0] result;
    logic                   is_halt;
  } mem_wb_t;

  // forwarding source, reg_write already qualified by valid
  typedef struct packed {
    logic [3:0]             rd;
    logic                   reg_write;
    logic [`CPU_DATA_W-1:0] value;
  } fwd_t;

  // output port write, low 15 bits of the byte address plus data
  typedef struct packed {
    logic [`CPU_IO_BIT-1:0] addr;
    logic [`CPU_DATA_W-1:0] data;
  } io_write_t;

endpackage

// ==== logic/cpu_regfile.sv ====
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpu_regfile (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [3:0]             rs,
  input  logic [3:0]             rt,
  input  logic                   wr_en,
  input  logic [3:0]             wr_addr,
  input  logic [`CPU_DATA_W-1:0] wr_data,
  output logic [`CPU_DATA_W-1:0] rs_val,
  output logic [`CPU_DATA_W-1:0] rt_val
);

  logic [`CPU_DATA_W-1:0] regs [16];
  logic                   wr_live;

  // writes to r0 are dropped so it stays zero
  assign wr_live = wr_en && (wr_addr != 4'd0);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 16; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_live) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // write-through, decode sees the value retiring this cycle
  assign rs_val = (wr_live && wr_addr == rs) ? wr_data : regs[rs];
  assign rt_val = (wr_live && wr_addr == rt) ? wr_data : regs[rt];

endmodule

// ==== logic/cpu_top.sv ====
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpu_top (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    prog_we,
  input  logic [`CPU_ADDR_W-1:0]  prog_addr,
  input  logic [`CPU_DATA_W-1:0]  prog_data,
  output logic [`CPU_DATA_W-1:0]  pc,
  output logic                    hlt,
  output cpu_isa_pkg::flags_t     flags,
  output logic                    io_valid,
  output cpu_pipe_pkg::io_write_t io_wr
);

  cpu_pipe_pkg::if_id_t  if_id;
  cpu_pipe_pkg::id_ex_t  id_ex;
  cpu_pipe_pkg::ex_mem_t ex_mem;
  cpu_pipe_pkg::fwd_t    mem_fwd;
  cpu_pipe_pkg::fwd_t    wb_fwd;
  logic                  halt_seen;

  // input side
  cpu_fetch cpu_fetch_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .prog_we   (prog_we),
    .prog_addr (prog_addr),
    .prog_data (prog_data),
    .halt_seen (halt_seen),
    .pc        (pc),
    .if_id     (if_id)
  );

  // decode also owns the register file, written from writeback
  cpu_decode cpu_decode_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .if_id     (if_id),
    .wb_fwd    (wb_fwd),
    .id_ex     (id_ex),
    .halt_seen (halt_seen)
  );

  cpu_execute cpu_execute_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .id_ex   (id_ex),
    .mem_fwd (mem_fwd),
    .wb_fwd  (wb_fwd),
    .ex_mem  (ex_mem),
    .flags   (flags)
  );

  // output side, data memory, output port and writeback
  cpu_memory cpu_memory_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .ex_mem   (ex_mem),
    .mem_fwd  (mem_fwd),
    .wb_fwd   (wb_fwd),
    .io_valid (io_valid),
    .io_wr    (io_wr),
    .hlt      (hlt)
  );

endmodule

// ==== project.f ====
+incdir+logic
logic/cpu_isa_pkg.sv
logic/cpu_pipe_pkg.sv
logic/cpu_fetch.sv
logic/cpu_regfile.sv
logic/cpu_decode.sv
logic/cpu_execute.sv
logic/cpu_memory.sv
logic/cpu_top.sv
tests/cpu_chk.sv
tests/cpu_tb.sv

// ==== run.sh ====
#!/bin/sh
# build with Verilator and run, exit status is the simulation result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module cpu_tb -f project.f -o cpu_sim &&
./obj_dir/cpu_sim || exit 1

// ==== tests/cpu_chk.sv ====
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpu_chk (
  input logic                   clk,
  input logic                   rst_n,
  input logic [`CPU_DATA_W-1:0] pc,
  input logic                   hlt,
  input logic                   io_valid
);

  // halt is sticky, only a reset brings it down
  hlt_sticky: assert property (@(posedge clk) $fell(hlt) |-> !$past(rst_n))
    else $error("hlt fell while rst_n was high");

  // fetch is frozen once the core has halted
  pc_frozen: assert property (@(posedge clk) disable iff (!rst_n) hlt |=> $stable(pc))
    else $error("pc moved while hlt was high");

  // port strobe comes out of reset low
  io_quiet_reset: assert property (@(posedge clk) !$past(rst_n) |-> !io_valid)
    else $error("io_valid high right after reset");

  // no stores can retire behind HLT
  io_quiet_halt: assert property (@(posedge clk) disable iff (!rst_n) !(io_valid && hlt))
    else $error("io_valid high while halted");

endmodule

// ==== tests/cpu_tb.sv ====
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpu_tb;

  logic                    clk;
  logic                    rst_n;
  logic                    prog_we;
  logic [`CPU_ADDR_W-1:0]  prog_addr;
  logic [`CPU_DATA_W-1:0]  prog_data;
  logic [`CPU_DATA_W-1:0]  pc;
  logic                    hlt;
  cpu_isa_pkg::flags_t     flags;
  logic                    io_valid;
  cpu_pipe_pkg::io_write_t io_wr;

  logic [31:0]             lcg_state;
  string                   test_name;
  logic [`CPU_DATA_W-1:0]  prog [$];
  cpu_pipe_pkg::io_write_t io_exp [$];
  cpu_pipe_pkg::io_write_t io_seen [$];
  logic [`CPU_DATA_W-1:0]  hlt_pc;

  cpu_top cpu_top_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .prog_we   (prog_we),
    .prog_addr (prog_addr),
    .prog_data (prog_data),
    .pc        (pc),
    .hlt       (hlt),
    .flags     (flags),
    .io_valid  (io_valid),
    .io_wr     (io_wr)
  );

  bind cpu_top cpu_chk cpu_chk_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .pc       (pc),
    .hlt      (hlt),
    .io_valid (io_valid)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // records every port write in arrival order
  always @(negedge clk) begin
    if (io_valid === 1'b1) begin
      io_seen.push_back(io_wr);
    end
  end

  // returns the next pseudo random byte
  function automatic logic [7:0] lcg_byte();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[23:16];
  endfunction

  task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("Error %s %s expected %0h actual %0h", test_name, what, exp, act);
      $display("*** FAILED ***");
      $fatal(1, "mismatch in %s", test_name);
    end
  endtask

  task automatic emit(input cpu_isa_pkg::opcode_e op, input logic [3:0] rd,
                      input logic [3:0] rs, input logic [3:0] rt);
    prog.push_back({op, rd, rs, rt});
  endtask

  task automatic emit_llb(input logic [3:0] rd, input logic [7:0] val);
    emit(cpu_isa_pkg::OP_LLB, rd, val[7:4], val[3:0]);
  endtask

  // SW through the port base in r15 with twice the slot as byte offset
  task automatic store_out(input logic [3:0] r, input logic [3:0] slot,
                           input logic [15:0] value);
    cpu_pipe_pkg::io_write_t w;
    w.addr = {10'd0, slot, 1'b0};
    w.data = value;
    emit(cpu_isa_pkg::OP_SW, r, 4'd15, slot);
    io_exp.push_back(w);
  endtask

  task automatic halt();
    hlt_pc = 16'(prog.size() * 2);
    emit(cpu_isa_pkg::OP_HLT, 4'd0, 4'd0, 4'd0);
  endtask

  // fresh program that first sets r15 to 0x8000 as the output port base
  task automatic new_test(input string name);
    test_name = name;
    prog.delete();
    io_exp.delete();
    emit_llb(4'd15, 8'h01);
    emit(cpu_isa_pkg::OP_SLL, 4'd15, 4'd15, 4'd15);
  endtask

  task automatic run_prog();
    int cycles;
    @(negedge clk);
    rst_n = 1'b0;
    // imem only takes writes while the core is in reset
    for (int i = 0; i < prog.size(); i++) begin
      prog_we   = 1'b1;
      prog_addr = `CPU_ADDR_W'(i);
      prog_data = prog[i];
      @(negedge clk);
    end
    prog_we = 1'b0;
    repeat (4) @(negedge clk);
    io_seen.delete();
    rst_n  = 1'b1;
    cycles = 0;
    while (hlt !== 1'b1) begin
      if (cycles == 200) begin
        $display("%s: hlt never came within 200 cycles", test_name);
        $display("*** FAILED ***");
        $fatal(1, "halt timeout");
      end
      @(negedge clk);
      cycles++;
    end
    check("output count", 32'(io_exp.size()), 32'(io_seen.size()));
    foreach (io_exp[k]) begin
      check("output addr", 32'(io_exp[k].addr), 32'(io_seen[k].addr));
      check("output data", 32'(io_exp[k].data), 32'(io_seen[k].data));
    end
  endtask

  task automatic arith_flags();
    logic [7:0]  a;
    logic [7:0]  b;
    logic [7:0]  c;
    logic [7:0]  d;
    logic [15:0] hx;
    logic [15:0] hy;
    logic [15:0] big;
    int          sum_s;
    logic        exp_v;
    new_test("arith_flags");
    a = lcg_byte();
    b = lcg_byte();
    // top bytes from 0x40 to 0x7f so the sum of two always overflows
    c = (lcg_byte() & 8'h3f) | 8'h40;
    d = (lcg_byte() & 8'h3f) | 8'h40;
    hx = {c, 8'h00};
    hy = {d, 8'h00};
    big = hx + hy;
    // overflow when the true signed sum leaves the 16-bit range
    sum_s = $signed(hx) + $signed(hy);
    exp_v = (sum_s > 32767) || (sum_s < -32768);
    emit_llb(4'd1, a);
    emit_llb(4'd2, b);
    emit(cpu_isa_pkg::OP_ADD, 4'd3, 4'd1, 4'd2);
    emit(cpu_isa_pkg::OP_SUB, 4'd4, 4'd1, 4'd2);
    emit_llb(4'd5, c);
    emit(cpu_isa_pkg::OP_SLL, 4'd5, 4'd5, 4'd8);
    emit_llb(4'd6, d);
    emit(cpu_isa_pkg::OP_SLL, 4'd6, 4'd6, 4'd8);
    emit(cpu_isa_pkg::OP_ADD, 4'd7, 4'd5, 4'd6);
    store_out(4'd3, 4'd0, {8'h00, a} + {8'h00, b});
    store_out(4'd4, 4'd1, {8'h00, a} - {8'h00, b});
    store_out(4'd7, 4'd2, big);
    halt();
    run_prog();
    check("flag v", 32'(exp_v), 32'(flags.v));
    check("flag n", 32'(big[15]), 32'(flags.n));
    check("flag z", 32'(big == 16'h0000), 32'(flags.z));
  endtask

  task automatic logic_shifts();
    logic [7:0]  a;
    logic [7:0]  b;
    logic [7:0]  c;
    logic [7:0]  t;
    logic [3:0]  s1;
    logic [3:0]  s2;
    logic [3:0]  s3;
    logic [15:0] x;
    new_test("logic_shifts");
    // top bit set so SRA has a sign to copy
    a = lcg_byte() | 8'h80;
    b = lcg_byte();
    c = lcg_byte();
    t = lcg_byte();
    s1 = t[3:0];
    s2 = t[7:4];
    t = lcg_byte();
    s3 = t[3:0];
    x = {a, b ^ c};
    emit_llb(4'd1, a);
    emit(cpu_isa_pkg::OP_SLL, 4'd1, 4'd1, 4'd8);
    emit_llb(4'd2, b);
    emit(cpu_isa_pkg::OP_XOR, 4'd1, 4'd1, 4'd2);
    emit_llb(4'd3, c);
    emit(cpu_isa_pkg::OP_XOR, 4'd4, 4'd1, 4'd3);
    emit(cpu_isa_pkg::OP_SLL, 4'd5, 4'd4, s1);
    emit(cpu_isa_pkg::OP_SRA, 4'd6, 4'd4, s2);
    emit(cpu_isa_pkg::OP_ROR, 4'd7, 4'd4, s3);
    emit(cpu_isa_pkg::OP_XOR, 4'd8, 4'd4, 4'd4);
    store_out(4'd4, 4'd0, x);
    store_out(4'd5, 4'd1, x << s1);
    // sign bit copied into the vacated top bits
    store_out(4'd6, 4'd2, (x >> s2) | ({16{x[15]}} << (5'd16 - {1'b0, s2})));
    store_out(4'd7, 4'd3, (x >> s3) | (x << (5'd16 - {1'b0, s3})));
    store_out(4'd8, 4'd4, 16'h0000);
    halt();
    run_prog();
    check("flag z", 32'd1, 32'(flags.z));
  endtask

  task automatic forwarding_chain();
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] v3;
    logic [15:0] v4;
    logic [15:0] v5;
    new_test("forwarding_chain");
    a = {8'h00, lcg_byte()};
    b = {8'h00, lcg_byte()};
    v3 = a + b;
    v4 = v3 + a;
    v5 = v4 + v4;
    emit_llb(4'd1, a[7:0]);
    emit_llb(4'd2, b[7:0]);
    // r2 comes from the memory stage and r1 from writeback
    emit(cpu_isa_pkg::OP_ADD, 4'd3, 4'd1, 4'd2);
    emit(cpu_isa_pkg::OP_ADD, 4'd4, 4'd3, 4'd1);
    emit(cpu_isa_pkg::OP_ADD, 4'd5, 4'd4, 4'd4);
    // r3 three back comes through the register file
    emit(cpu_isa_pkg::OP_ADD, 4'd6, 4'd5, 4'd3);
    store_out(4'd6, 4'd0, v5 + v3);
    store_out(4'd3, 4'd1, v3);
    store_out(4'd4, 4'd2, v4);
    store_out(4'd5, 4'd3, v5);
    halt();
    run_prog();
  endtask

  task automatic memory_roundtrip();
    logic [7:0] a;
    logic [7:0] b;
    logic [7:0] c;
    new_test("memory_roundtrip");
    a = lcg_byte();
    b = lcg_byte();
    c = lcg_byte();
    emit_llb(4'd1, a);
    emit_llb(4'd2, b);
    emit(cpu_isa_pkg::OP_SLL, 4'd2, 4'd2, 4'd4);
    emit_llb(4'd3, 8'h10);
    emit_llb(4'd9, c);
    // stores to byte addresses 2, 4 and 0x0e
    emit(cpu_isa_pkg::OP_SW, 4'd1, 4'd0, 4'd1);
    emit(cpu_isa_pkg::OP_SW, 4'd2, 4'd0, 4'd2);
    emit(cpu_isa_pkg::OP_SW, 4'd9, 4'd3, 4'hf);
    emit(cpu_isa_pkg::OP_LW, 4'd4, 4'd0, 4'd1);
    emit(cpu_isa_pkg::OP_ADD, 4'd5, 4'd4, 4'd1);
    emit(cpu_isa_pkg::OP_LW, 4'd6, 4'd3, 4'hf);
    emit(cpu_isa_pkg::OP_ADD, 4'd7, 4'd6, 4'd6);
    emit(cpu_isa_pkg::OP_LW, 4'd8, 4'd0, 4'd2);
    store_out(4'd8, 4'd0, {4'h0, b, 4'h0});
    store_out(4'd5, 4'd1, {8'h00, a} + {8'h00, a});
    store_out(4'd7, 4'd2, {8'h00, c} + {8'h00, c});
    store_out(4'd4, 4'd3, {8'h00, a});
    halt();
    run_prog();
  endtask

  task automatic halt_and_r0();
    logic [15:0] held;
    new_test("halt_and_r0");
    emit_llb(4'd0, 8'h5a);
    store_out(4'd0, 4'd0, 16'h0000);
    emit(cpu_isa_pkg::OP_ADD, 4'd0, 4'd15, 4'd15);
    store_out(4'd0, 4'd1, 16'h0000);
    halt();
    // never fetched so never seen on the port
    emit_llb(4'd1, 8'h77);
    emit(cpu_isa_pkg::OP_SW, 4'd1, 4'd15, 4'd2);
    run_prog();
    check("pc at halt", 32'(hlt_pc + 16'd2), 32'(pc));
    held = pc;
    repeat (20) begin
      @(negedge clk);
      check("pc held", 32'(held), 32'(pc));
    end
    check("output count", 32'(io_exp.size()), 32'(io_seen.size()));
  endtask

  initial begin
    rst_n     = 1'b0;
    prog_we   = 1'b0;
    prog_addr = '0;
    prog_data = '0;
    lcg_state = 32'h5f94_c585;
    arith_flags();
    logic_shifts();
    forwarding_chain();
    memory_roundtrip();
    halt_and_r0();
    $display("*** PASSED ***");
    $finish;
  end

endmodule
